// ==== Bender.yml ====
package:
  name: core_slice

sources:
  # design, package first.
  - core_pkg.sv
  - decode_stage.sv
  - reg_file.sv
  - execute_stage.sv
  - core_slice.sv

  # testbench.
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_core_slice.sv

// ==== core_pkg.sv ====
package core_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int WORD   = 32;
    localparam int W_RD   = 4;
    localparam int W_IMM  = 16;
    localparam int W_OPC  = 5;
    localparam int N_REG  = 16;
    localparam int D_INFO = 4;
    localparam int W_SH   = 5;  // shift amount, low bits of opr1.

    // instruction field positions.
    localparam int OPC_LSB  = WORD - W_OPC;
    localparam int IMMF_BIT = OPC_LSB - 1;
    localparam int R0_LSB   = W_IMM + 2 + W_RD;
    localparam int R1_LSB   = W_IMM + 2;

    // decode info bits.
    localparam int DI_IMM  = 3;
    localparam int DI_SEXT = 2;
    localparam int DI_WR   = 1;
    localparam int DI_SUM  = 0;

    typedef logic [WORD-1:0]   word_t;
    typedef logic [WORD-1:0]   addr_t;
    typedef logic [W_RD-1:0]   reg_idx_t;
    typedef logic [W_IMM-1:0]  imm_t;
    typedef logic [D_INFO-1:0] d_info_t;

    typedef enum logic [W_OPC-1:0] {
        OP_NOP = 5'd0,
        OP_ADD = 5'd1,
        OP_SUB = 5'd2,
        OP_AND = 5'd3,
        OP_OR  = 5'd4,
        OP_XOR = 5'd5,
        OP_SHL = 5'd6,
        OP_SHR = 5'd7,
        OP_SLT = 5'd8,
        OP_LI  = 5'd9,
        OP_LIU = 5'd10
    } opcode_e;

    // top six instruction bits: opcode then immediate-form flag.
    function automatic d_info_t decode_info(input logic [W_OPC:0] top_i);
        logic    immf;
        d_info_t info;
        immf = top_i[0];
        case (opcode_e'(top_i[W_OPC:1]))
            OP_NOP:  info = 4'b0000;
            OP_LI:   info = 4'b1110;  // sign-extended load.
            OP_LIU:  info = 4'b1010;  // zero-extended load.
            default: begin
                // alu ops, immediate form adds r1.
                info = immf ? 4'b1111 : 4'b0010;
            end
        endcase
        return info;
    endfunction

endpackage

// ==== core_slice.sv ====
`timescale 1ns/1ps

module core_slice (
    input  logic               clk,
    input  logic               reset,
    input  logic               v_i,
    input  core_pkg::word_t    inst_i,
    input  core_pkg::addr_t    pc_i,
    input  logic               stall_i,
    output logic               stall_o,
    output logic               result_v_o,
    output core_pkg::word_t    result_o,
    output core_pkg::reg_idx_t result_r_o,
    output core_pkg::addr_t    result_pc_o
);
    import core_pkg::*;

    // decode to register block.
    reg_idx_t r0;
    reg_idx_t r1;
    logic     w_reserve;
    logic     reserved;
    word_t    rf_opr0;
    word_t    rf_opr1;

    // decode to execute.
    logic     dec_v;
    opcode_e  opcode;
    word_t    opr0;
    word_t    opr1;
    reg_idx_t wb_r;
    addr_t    dec_pc;
    logic     ex_stall;

    logic     wb_v;

    // ****************************************
    // stages
    // ****************************************
    decode_stage i_decode (
        .clk         (clk),
        .reset       (reset),
        .v_i         (v_i),
        .stall_i     (ex_stall),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .r_opr0_i    (rf_opr0),
        .r_opr1_i    (rf_opr1),
        .reserved_i  (reserved),
        .v_o         (dec_v),
        .stall_o     (stall_o),
        .pc_o        (dec_pc),
        .r0_o        (r0),
        .r1_o        (r1),
        .w_reserve_o (w_reserve),
        .opcode_o    (opcode),
        .opr0_o      (opr0),
        .opr1_o      (opr1),
        .wb_r_o      (wb_r)
    );

    reg_file i_reg_file (
        .clk         (clk),
        .reset       (reset),
        .rd_en_i     (~ex_stall),  // read on decode capture edges.
        .rs0_i       (r0),
        .rs1_i       (r1),
        .reserve_i   (w_reserve),
        .reserve_r_i (r0),
        .wb_v_i      (wb_v),
        .wb_r_i      (result_r_o),
        .wb_data_i   (result_o),
        .opr0_o      (rf_opr0),
        .opr1_o      (rf_opr1),
        .reserved_o  (reserved)
    );

    execute_stage i_execute (
        .clk         (clk),
        .reset       (reset),
        .v_i         (dec_v),
        .stall_i     (stall_i),
        .opcode_i    (opcode),
        .opr0_i      (opr0),
        .opr1_i      (opr1),
        .wb_r_i      (wb_r),
        .pc_i        (dec_pc),
        .stall_o     (ex_stall),
        .result_v_o  (result_v_o),
        .result_o    (result_o),
        .result_r_o  (result_r_o),
        .result_pc_o (result_pc_o),
        .wb_v_o      (wb_v)
    );

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               v_i,
    input  logic               stall_i,
    input  core_pkg::word_t    inst_i,
    input  core_pkg::addr_t    pc_i,
    input  core_pkg::word_t    r_opr0_i,
    input  core_pkg::word_t    r_opr1_i,
    input  logic               reserved_i,
    output logic               v_o,
    output logic               stall_o,
    output core_pkg::addr_t    pc_o,
    output core_pkg::reg_idx_t r0_o,
    output core_pkg::reg_idx_t r1_o,
    output logic               w_reserve_o,
    output core_pkg::opcode_e  opcode_o,
    output core_pkg::word_t    opr0_o,
    output core_pkg::word_t    opr1_o,
    output core_pkg::reg_idx_t wb_r_o
);
    import core_pkg::*;

    // registered decode state.
    logic     v_q;
    logic     reserved_q;
    opcode_e  opcode_q;
    reg_idx_t wb_r_q;
    word_t    imm_q;
    logic     immf_q;
    logic     sum_q;
    addr_t    pc_q;

    opcode_e  opcode;
    imm_t     imm;
    d_info_t  d_info;
    word_t    imm_ext;
    logic     hazard;

    // ****************************************
    // field split
    // ****************************************
    assign opcode = opcode_e'(inst_i[WORD-1:OPC_LSB]);
    assign d_info = decode_info(inst_i[WORD-1:IMMF_BIT]);
    assign r0_o   = inst_i[R0_LSB +: W_RD];
    assign r1_o   = inst_i[R1_LSB +: W_RD];
    assign imm    = inst_i[W_IMM-1:0];

    always_comb begin
        if (d_info[DI_SEXT]) begin
            imm_ext = {{(WORD-W_IMM){imm[W_IMM-1]}}, imm};
        end else begin
            imm_ext = {{(WORD-W_IMM){1'b0}}, imm};
        end
    end

    // pending write on r0 or r1, nop never waits.
    assign hazard = v_i & d_info[DI_WR] & reserved_i;

    // source holds while execute is full or a source is still reserved.
    assign stall_o = stall_i | hazard;

    // reserve only when the instruction really moves on this edge.
    assign w_reserve_o = v_i & d_info[DI_WR] & ~stall_o;

    // ****************************************
    // outputs
    // ****************************************
    assign v_o      = v_q & ~reserved_q;  // retry slot is a bubble.
    assign opcode_o = opcode_q;
    assign wb_r_o   = wb_r_q;
    assign pc_o     = pc_q;
    assign opr0_o   = r_opr0_i;

    always_comb begin
        if (!immf_q) begin
            opr1_o = r_opr1_i;
        end else if (sum_q) begin
            opr1_o = imm_q + r_opr1_i;
        end else begin
            opr1_o = imm_q;
        end
    end

    // control.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            v_q        <= 1'b0;
            reserved_q <= 1'b0;
        end else if (!stall_i) begin
            v_q        <= v_i;
            reserved_q <= hazard;
        end
    end

    // payload, same edges as the register read.
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            opcode_q <= opcode;
            wb_r_q   <= r0_o;
            imm_q    <= imm_ext;
            immf_q   <= d_info[DI_IMM];
            sum_q    <= d_info[DI_SUM];
            pc_q     <= pc_i;
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               v_i,
    input  logic               stall_i,
    input  core_pkg::opcode_e  opcode_i,
    input  core_pkg::word_t    opr0_i,
    input  core_pkg::word_t    opr1_i,
    input  core_pkg::reg_idx_t wb_r_i,
    input  core_pkg::addr_t    pc_i,
    output logic               stall_o,
    output logic               result_v_o,
    output core_pkg::word_t    result_o,
    output core_pkg::reg_idx_t result_r_o,
    output core_pkg::addr_t    result_pc_o,
    output logic               wb_v_o
);
    import core_pkg::*;

    logic     res_v_q;
    word_t    res_q;
    reg_idx_t res_r_q;
    addr_t    res_pc_q;

    word_t             alu;
    logic [W_SH-1:0]   shamt;
    logic              load;
    logic              take;

    assign shamt = opr1_i[W_SH-1:0];

    // ****************************************
    // alu
    // ****************************************
    always_comb begin
        case (opcode_i)
            OP_ADD: alu = opr0_i + opr1_i;
            OP_SUB: alu = opr0_i - opr1_i;
            OP_AND: alu = opr0_i & opr1_i;
            OP_OR:  alu = opr0_i | opr1_i;
            OP_XOR: alu = opr0_i ^ opr1_i;
            OP_SHL: alu = opr0_i << shamt;
            OP_SHR: alu = opr0_i >> shamt;  // logical.
            OP_SLT: begin
                alu = {{(WORD-1){1'b0}}, $signed(opr0_i) < $signed(opr1_i)};
            end
            OP_LI, OP_LIU: alu = opr1_i;  // immediate already formed in decode.
            default: alu = '0;
        endcase
    end

    // hold while a result waits on the consumer.
    assign stall_o = res_v_q & stall_i;
    assign load    = ~stall_o;
    assign take    = res_v_q & ~stall_i;

    // ****************************************
    // result register
    // ****************************************
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            res_v_q <= 1'b0;
        end else if (load) begin
            res_v_q <= v_i & (opcode_i != OP_NOP);  // nop leaves no result.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_q    <= alu;
            res_r_q  <= wb_r_i;
            res_pc_q <= pc_i;
        end
    end

    assign result_v_o  = res_v_q;
    assign result_o    = res_q;
    assign result_r_o  = res_r_q;
    assign result_pc_o = res_pc_q;

    // write-back fires on the edge the result is taken.
    assign wb_v_o = take;

endmodule

// ==== list.f ====
core_pkg.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
core_slice.sv
tb_clock_gen.sv
tb_core_slice.sv

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_en_i,
    input  core_pkg::reg_idx_t rs0_i,
    input  core_pkg::reg_idx_t rs1_i,
    input  logic               reserve_i,
    input  core_pkg::reg_idx_t reserve_r_i,
    input  logic               wb_v_i,
    input  core_pkg::reg_idx_t wb_r_i,
    input  core_pkg::word_t    wb_data_i,
    output core_pkg::word_t    opr0_o,
    output core_pkg::word_t    opr1_o,
    output logic               reserved_o
);
    import core_pkg::*;

    word_t            regs_q [N_REG];
    logic [N_REG-1:0] rsv_q;  // one reservation bit per register.
    word_t            opr0_q;
    word_t            opr1_q;

    logic  hit0;
    logic  hit1;
    word_t rd0;
    word_t rd1;

    // write-back to a source on this edge.
    assign hit0 = wb_v_i & (wb_r_i == rs0_i);
    assign hit1 = wb_v_i & (wb_r_i == rs1_i);

    assign rd0 = hit0 ? wb_data_i : regs_q[rs0_i];  // bypass.
    assign rd1 = hit1 ? wb_data_i : regs_q[rs1_i];

    // a bit cleared on this edge no longer blocks, the bypass covers it.
    assign reserved_o = (rsv_q[rs0_i] & ~hit0) | (rsv_q[rs1_i] & ~hit1);

    // ****************************************
    // register array
    // ****************************************
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < N_REG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_v_i) begin
            regs_q[wb_r_i] <= wb_data_i;
        end
    end

    // set wins over clear on the same register.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rsv_q <= '0;
        end else begin
            if (wb_v_i) begin
                rsv_q[wb_r_i] <= 1'b0;
            end
            if (reserve_i) begin
                rsv_q[reserve_r_i] <= 1'b1;
            end
        end
    end

    // ****************************************
    // operand read
    // ****************************************
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            opr0_q <= rd0;
            opr1_q <= rd1;
        end
    end

    assign opr0_o = opr0_q;
    assign opr1_o = opr1_q;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 100 ns period.
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // low for three rising edges, released on a falling edge.
    initial begin
        reset_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b1;
    end

endmodule

// ==== tb_core_slice.sv ====
`timescale 1ns/1ps

module tb_core_slice;
    import core_pkg::*;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 500;

    logic     clk;
    logic     reset;
    logic     v_i;
    word_t    inst_i;
    addr_t    pc_i;
    logic     stall_i;
    logic     stall_o;
    logic     result_v_o;
    word_t    result_o;
    reg_idx_t result_r_o;
    addr_t    result_pc_o;

    logic [31:0] rnd_state    = 32'h8e3;
    int          stall_pct    = 0;   // percent of cycles with stall_i high.
    int          value_errors = 0;
    int          other_errors = 0;
    logic        timed_out    = 1'b0;
    addr_t       pc_next      = 32'h1000;
    logic        reset_prev   = 1'b0;
    logic        hold_q       = 1'b0;
    word_t       held_data;
    reg_idx_t    held_r;
    addr_t       held_pc;

    // reference model state.
    word_t    model_regs [N_REG];
    word_t    exp_data_q [$];
    reg_idx_t exp_r_q [$];
    addr_t    exp_pc_q [$];

    tb_clock_gen i_clock_gen (.clk_o(clk), .reset_o(reset));

    core_slice i_dut (.*);

    // xorshift32.
    function automatic logic [31:0] next_random();
        rnd_state ^= rnd_state << 13;
        rnd_state ^= rnd_state >> 17;
        rnd_state ^= rnd_state << 5;
        return rnd_state;
    endfunction

    function automatic word_t encode(input logic [4:0] op, input logic immf,
                                     input reg_idx_t d, input reg_idx_t s, input imm_t imm);
        return {op, immf, d, s, 2'b00, imm};
    endfunction

    function automatic word_t random_inst();
        logic [31:0] r;
        logic [31:0] r_imm;
        logic [31:0] pick;
        reg_idx_t    d;
        reg_idx_t    s;
        r     = next_random();
        r_imm = next_random();
        pick  = r % 11;
        d     = r[11] ? {2'b00, r[13:12]} : r[15:12];  // fewer registers give more hazards.
        s     = r[10] ? {2'b00, r[17:16]} : r[19:16];
        return encode(pick[4:0], r[9], d, s, r_imm[15:0]);
    endfunction

    // ****************************************
    // reference model and checks
    // ****************************************
    task automatic model_accept(input word_t inst, input addr_t pc);
        logic [4:0] op;
        reg_idx_t   d;
        reg_idx_t   s;
        word_t      sext;
        word_t      a;
        word_t      b;
        word_t      res;
        op   = inst[31:27];
        d    = inst[25:22];
        s    = inst[21:18];
        sext = {{16{inst[15]}}, inst[15:0]};
        a    = model_regs[d];  // r0 is also the first source.
        if (op == OP_LI) begin
            b = sext;
        end else if (op == OP_LIU) begin
            b = {16'h0000, inst[15:0]};
        end else if (inst[26]) begin
            b = sext + model_regs[s];
        end else begin
            b = model_regs[s];
        end
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SHL:  res = a << b[4:0];
            OP_SHR:  res = a >> b[4:0];
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = b;  // loads.
        endcase
        if (op != OP_NOP) begin
            model_regs[d] = res;
            exp_data_q.push_back(res);
            exp_r_q.push_back(d);
            exp_pc_q.push_back(pc);
        end
    endtask

    task automatic check_result();
        word_t    exp_data;
        reg_idx_t exp_r;
        addr_t    exp_pc;
        if (exp_data_q.size() == 0) begin
            other_errors++;
            $display("Result at pc %h arrived with no instruction pending", result_pc_o);
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_r    = exp_r_q.pop_front();
            exp_pc   = exp_pc_q.pop_front();
            assert (result_o == exp_data) else begin
                value_errors++;
                $display("** Error: result_o = %h, expected %h", result_o, exp_data);
            end
            assert (result_r_o == exp_r) else begin
                value_errors++;
                $display("** Error: result_r_o = %h, expected %h", result_r_o, exp_r);
            end
            assert (result_pc_o == exp_pc) else begin
                value_errors++;
                $display("** Error: result_pc_o = %h, expected %h", result_pc_o, exp_pc);
            end
        end
    endtask

    task automatic check_held();
        assert (result_v_o) else begin
            other_errors++;
            $display("result_v_o dropped while stall_i held the result");
        end
        assert (result_o == held_data && result_r_o == held_r && result_pc_o == held_pc)
        else begin
            value_errors++;
            $display("** Error: result_o = %h, result_r_o = %h, result_pc_o = %h, held %h %h %h",
                     result_o, result_r_o, result_pc_o, held_data, held_r, held_pc);
        end
    endtask

    // sample half a cycle before each rising edge.
    always @(negedge clk) begin
        #1;
        if (!reset || !reset_prev) begin
            assert (!stall_o && !result_v_o) else begin
                value_errors++;
                $display("** Error: stall_o = %h, result_v_o = %h around reset, expected 0",
                         stall_o, result_v_o);
            end
        end
        if (reset) begin
            if (hold_q) check_held();
            if (result_v_o && !stall_i) check_result();
            if (v_i && !stall_o) model_accept(inst_i, pc_i);
            hold_q    = result_v_o && stall_i;
            held_data = result_o;
            held_r    = result_r_o;
            held_pc   = result_pc_o;
        end
        reset_prev = reset;
    end

    // ****************************************
    // stimulus
    // ****************************************
    task automatic next_cycle();
        @(negedge clk);
        stall_i = (stall_pct != 0) && ((next_random() % 100) < stall_pct);
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // hold the instruction until the DUT takes it.
    task automatic issue(input word_t inst);
        int waited;
        waited = 0;
        if (!timed_out) begin
            v_i    = 1'b1;
            inst_i = inst;
            pc_i   = pc_next;
            #1;
            while (stall_o && !timed_out) begin
                next_cycle();
                #1;
                waited++;
                if (waited > ACCEPT_LIMIT) begin
                    $display("Timeout: instruction at pc %h was never accepted", pc_next);
                    other_errors++;
                    timed_out = 1'b1;
                end
            end
            next_cycle();
            v_i     = 1'b0;
            pc_next = pc_next + 4;
        end
    endtask

    task automatic run_directed();
        stall_pct = 0;
        issue(encode(OP_LI,  1'b0, 4'd1, 4'd0, 16'hfffb));  // -5.
        issue(encode(OP_LIU, 1'b0, 4'd2, 4'd0, 16'h8001));
        issue(encode(OP_LI,  1'b1, 4'd3, 4'd0, 16'h0007));
        issue(encode(OP_LI,  1'b0, 4'd4, 4'd0, 16'h8001));
        issue(encode(OP_LI,  1'b0, 4'd7, 4'd0, 16'h0024));  // shift by 4.
        issue(encode(OP_ADD, 1'b0, 4'd2, 4'd3, 16'h0000));
        issue(encode(OP_SUB, 1'b0, 4'd3, 4'd1, 16'h0000));
        issue(encode(OP_AND, 1'b0, 4'd2, 4'd4, 16'h0000));
        issue(encode(OP_OR,  1'b0, 4'd4, 4'd3, 16'h0000));
        issue(encode(OP_XOR, 1'b0, 4'd2, 4'd1, 16'h0000));
        issue(encode(OP_SLT, 1'b0, 4'd1, 4'd3, 16'h0000));  // negative less than positive.
        issue(encode(OP_SLT, 1'b0, 4'd3, 4'd4, 16'h0000));
        issue(encode(OP_SHL, 1'b0, 4'd4, 4'd7, 16'h0000));
        issue(encode(OP_SHR, 1'b0, 4'd4, 4'd7, 16'h0000));
        issue(encode(OP_ADD, 1'b1, 4'd8, 4'd2, 16'hfffe));
        // dependent chain.
        issue(encode(OP_LI,  1'b0, 4'd5, 4'd0, 16'h0003));
        repeat (4) issue(encode(OP_ADD, 1'b0, 4'd5, 4'd5, 16'h0000));
        repeat (3) issue(encode(OP_ADD, 1'b1, 4'd5, 4'd5, 16'h0001));
    endtask

    task automatic run_random(input int count, input int pct);
        stall_pct = pct;
        for (int i = 0; i < count; i++) begin
            issue(random_inst());
            if ((next_random() & 32'h7) == 0) idle(1 + next_random() % 3);
        end
    endtask

    task automatic drain();
        int waited;
        waited    = 0;
        stall_pct = 0;
        while (exp_data_q.size() != 0 && !timed_out) begin
            next_cycle();
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Timeout: %0d results still pending", exp_data_q.size());
                other_errors++;
                timed_out = 1'b1;
            end
        end
        idle(4);  // late duplicates show up here.
    endtask

    initial begin
        int waited;
        // a writing instruction and downstream stall wait through reset.
        v_i     = 1'b1;
        inst_i  = encode(OP_LI, 1'b0, 4'd6, 4'd6, 16'h00a5);
        pc_i    = 32'h0ffc;
        stall_i = 1'b1;
        for (int i = 0; i < N_REG; i++) begin
            model_regs[i] = '0;
        end
        waited = 0;
        while (reset !== 1'b1 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                $display("Timeout: reset was never released");
                other_errors++;
                timed_out = 1'b1;
            end
        end
        next_cycle();
        v_i = 1'b0;
        run_directed();
        run_random(150, 0);
        run_random(200, 35);
        drain();
        assert (exp_data_q.size() == 0) else begin
            other_errors++;
            $display("%0d expected results were never produced", exp_data_q.size());
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
